// File: rtl/psd_pkg.sv
package psd_pkg;

    localparam int SAMPLE_W = 16;
    localparam int Q_FRAC   = 15;
    localparam int POWER_W  = 32;
    localparam int NF_MAX   = 64;   // Twiddle table size

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_t;

    // Frame sequencing
    typedef enum logic [1:0] {
        LOAD,
        COMPUTE,
        FLUSH,
        DRAIN
    } psd_state_t;

endpackage

// File: rtl/fft_mem_if.sv
`timescale 1ns/1ps

interface fft_mem_if #(
    parameter int AW = 4
);
    import psd_pkg::*;

    logic          rd_en;
    logic [AW-1:0] rd_addr_a;
    logic [AW-1:0] rd_addr_b;
    cplx_t         rd_data_a;   // Valid one cycle after rd_en
    cplx_t         rd_data_b;

    logic          wr_en;
    logic [AW-1:0] wr_addr_a;
    logic [AW-1:0] wr_addr_b;
    cplx_t         wr_data_a;
    cplx_t         wr_data_b;

    modport ctrl (
        output rd_en, rd_addr_a, rd_addr_b
    );

    modport bfly (
        input  rd_addr_a, rd_addr_b, rd_data_a, rd_data_b,
        output wr_en, wr_addr_a, wr_addr_b, wr_data_a, wr_data_b
    );

    modport mem (
        input  rd_en, rd_addr_a, rd_addr_b,
        input  wr_en, wr_addr_a, wr_addr_b, wr_data_a, wr_data_b,
        output rd_data_a, rd_data_b
    );

endinterface

// File: rtl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
    parameter int NF = 16
) (
    input  logic                  clk,
    input  logic                  load_en,
    input  logic [$clog2(NF)-1:0] load_addr,
    input  psd_pkg::cplx_t        load_data,
    input  logic                  drain_en,
    input  logic [$clog2(NF)-1:0] drain_addr,
    output psd_pkg::cplx_t        drain_data,
    fft_mem_if.mem                mem
);
    import psd_pkg::*;

    localparam int AW = $clog2(NF);

    cplx_t         ram [NF];
    logic [AW-1:0] wa_addr;
    cplx_t         wa_data;
    logic          wa_en;
    logic [AW-1:0] rb_addr;
    cplx_t         rb_q;

    // Port A write is shared between sample load and butterfly
    assign wa_en   = load_en || mem.wr_en;
    assign wa_addr = load_en ? load_addr : mem.wr_addr_a;
    assign wa_data = load_en ? load_data : mem.wr_data_a;

    assign rb_addr = drain_en ? drain_addr : mem.rd_addr_b;   // Drain borrows read port B

    always_ff @(posedge clk) begin
        if (wa_en) begin
            ram[wa_addr] <= wa_data;
        end
        if (mem.wr_en) begin
            ram[mem.wr_addr_b] <= mem.wr_data_b;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data_a <= ram[mem.rd_addr_a];
        end
        if (mem.rd_en || drain_en) begin
            rb_q <= ram[rb_addr];
        end
    end

    assign mem.rd_data_b = rb_q;
    assign drain_data    = rb_q;

    // Loads only happen in LOAD, butterfly writes only while computing
    a_no_load_during_compute: assert property (@(posedge clk) load_en |-> !mem.wr_en);

endmodule

// File: rtl/twiddle_rom.sv
`timescale 1ns/1ps

module twiddle_rom #(
    parameter int NF = 16
) (
    input  logic                  clk,
    input  logic [$clog2(NF)-1:0] tw_addr,
    output psd_pkg::cplx_t        tw
);
    import psd_pkg::*;

    localparam int STRIDE = NF_MAX / NF;
    localparam int PW     = $clog2(NF_MAX / 2);

    // Pair k is re then im of exp(-j*2*pi*k/64)
    logic [SAMPLE_W-1:0] rom [NF_MAX];
    logic [PW-1:0]       pair_idx;

    initial begin
        $readmemh("rtl/twiddle_q15.mem", rom);
    end

    assign pair_idx = PW'(tw_addr * STRIDE);

    always_ff @(posedge clk) begin
        tw.re <= rom[{pair_idx, 1'b0}];
        tw.im <= rom[{pair_idx, 1'b1}];
    end

    // Controller only ever asks for the upper half-circle
    a_tw_addr_range: assert property (
        @(posedge clk) !$isunknown(tw_addr) |-> (tw_addr < NF / 2)
    );

endmodule

// File: rtl/butterfly_unit.sv
`timescale 1ns/1ps

module butterfly_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           bfly_valid,
    input  psd_pkg::cplx_t tw,
    fft_mem_if.bfly        bfly
);
    import psd_pkg::*;

    localparam int AW  = $bits(bfly.rd_addr_a);
    localparam int PW  = 2 * SAMPLE_W;        // Full product width
    localparam int TPW = PW + 1 - Q_FRAC;     // Twiddled operand width

    localparam logic signed [TPW:0] MAX_S = 2 ** (SAMPLE_W - 1) - 1;
    localparam logic signed [TPW:0] MIN_S = -(2 ** (SAMPLE_W - 1));

    logic                  v1;
    logic                  v2;
    logic [AW-1:0]         addr_a1;
    logic [AW-1:0]         addr_b1;
    logic [AW-1:0]         addr_a2;
    logic [AW-1:0]         addr_b2;
    cplx_t                 a2;
    logic signed [PW-1:0]  p_rr;
    logic signed [PW-1:0]  p_ii;
    logic signed [PW-1:0]  p_ri;
    logic signed [PW-1:0]  p_ir;
    logic signed [PW:0]    t_re_full;
    logic signed [PW:0]    t_im_full;
    logic signed [TPW-1:0] t_re;
    logic signed [TPW-1:0] t_im;
    logic signed [TPW:0]   sum_re;
    logic signed [TPW:0]   sum_im;
    logic signed [TPW:0]   dif_re;
    logic signed [TPW:0]   dif_im;

    function automatic logic signed [SAMPLE_W-1:0] sat(input logic signed [TPW:0] v);
        if (v > MAX_S) begin
            return {1'b0, {(SAMPLE_W - 1){1'b1}}};
        end
        if (v < MIN_S) begin
            return {1'b1, {(SAMPLE_W - 1){1'b0}}};
        end
        return v[SAMPLE_W-1:0];
    endfunction

    // t = b * W, back to Q15
    assign t_re_full = p_rr - p_ii;
    assign t_im_full = p_ri + p_ir;
    assign t_re      = TPW'(t_re_full >>> Q_FRAC);
    assign t_im      = TPW'(t_im_full >>> Q_FRAC);

    assign sum_re = a2.re + t_re;
    assign sum_im = a2.im + t_im;
    assign dif_re = a2.re - t_re;
    assign dif_im = a2.im - t_im;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1         <= 1'b0;
            v2         <= 1'b0;
            bfly.wr_en <= 1'b0;
        end else begin
            v1         <= bfly_valid;
            v2         <= v1;
            bfly.wr_en <= v2;
        end
    end

    always_ff @(posedge clk) begin
        addr_a1 <= bfly.rd_addr_a;   // Read issued this cycle
        addr_b1 <= bfly.rd_addr_b;

        addr_a2 <= addr_a1;
        addr_b2 <= addr_b1;
        a2      <= bfly.rd_data_a;
        p_rr    <= bfly.rd_data_b.re * tw.re;
        p_ii    <= bfly.rd_data_b.im * tw.im;
        p_ri    <= bfly.rd_data_b.re * tw.im;
        p_ir    <= bfly.rd_data_b.im * tw.re;

        bfly.wr_addr_a    <= addr_a2;
        bfly.wr_addr_b    <= addr_b2;
        bfly.wr_data_a.re <= sat(sum_re >>> 1);   // Halve every stage
        bfly.wr_data_a.im <= sat(sum_im >>> 1);
        bfly.wr_data_b.re <= sat(dif_re >>> 1);
        bfly.wr_data_b.im <= sat(dif_im >>> 1);
    end

endmodule

// File: rtl/fft_controller.sv
`timescale 1ns/1ps

module fft_controller #(
    parameter int NF = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample_valid,
    output logic                  load_en,
    output logic [$clog2(NF)-1:0] load_addr,
    output logic                  busy,
    output logic [$clog2(NF)-1:0] tw_addr,
    output logic                  bfly_valid,
    output logic                  drain_en,
    output logic [$clog2(NF)-1:0] drain_addr,
    output logic                  pwr_valid_in,
    output logic                  pwr_last_in,
    fft_mem_if.ctrl               ctrl
);
    import psd_pkg::*;

    localparam int AW = $clog2(NF);
    localparam int SW = $clog2(AW);

    psd_state_t    state;
    logic [AW-1:0] load_cnt;
    logic [SW-1:0] stage;
    logic [AW-2:0] bfly_idx;
    logic [1:0]    flush_cnt;
    logic [AW:0]   drain_cnt;   // Runs two past NF for the output tail
    logic [AW-1:0] j;
    logic [AW-1:0] half_mask;
    logic [AW-1:0] pos;
    logic [AW-1:0] addr_a;

    function automatic logic [AW-1:0] bitrev(input logic [AW-1:0] v);
        logic [AW-1:0] r;
        for (int i = 0; i < AW; i++) begin
            r[i] = v[AW-1-i];
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= LOAD;
            load_cnt     <= '0;
            stage        <= '0;
            bfly_idx     <= '0;
            flush_cnt    <= '0;
            drain_cnt    <= '0;
            pwr_valid_in <= 1'b0;
            pwr_last_in  <= 1'b0;
        end else begin
            pwr_valid_in <= drain_en;   // Lines up with buffer read data
            pwr_last_in  <= drain_en && (drain_cnt == NF - 1);
            case (state)
                LOAD: begin
                    if (sample_valid) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_cnt == '1) begin
                            state <= COMPUTE;
                        end
                    end
                end
                COMPUTE: begin
                    bfly_idx <= bfly_idx + 1'b1;
                    if (bfly_idx == '1) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == 2'd2) begin   // Last write of the stage lands here
                        flush_cnt <= '0;
                        if (stage == AW - 1) begin
                            stage     <= '0;
                            drain_cnt <= '0;
                            state     <= DRAIN;
                        end else begin
                            stage <= stage + 1'b1;
                            state <= COMPUTE;
                        end
                    end
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == NF + 1) begin
                        state <= LOAD;
                    end
                end
                default: state <= LOAD;
            endcase
        end
    end

    assign busy      = (state != LOAD);
    assign load_en   = (state == LOAD) && sample_valid;
    assign load_addr = bitrev(load_cnt);

    // Pair addresses for DIT stage s with span 2^s
    assign j         = {1'b0, bfly_idx};
    assign half_mask = (AW'(1) << stage) - AW'(1);
    assign pos       = j & half_mask;
    assign addr_a    = ((j & ~half_mask) << 1) | pos;

    assign ctrl.rd_en     = (state == COMPUTE);
    assign ctrl.rd_addr_a = addr_a;
    assign ctrl.rd_addr_b = addr_a | (half_mask + AW'(1));
    assign bfly_valid     = (state == COMPUTE);
    assign tw_addr        = pos << (AW - 1 - stage);

    assign drain_en   = (state == DRAIN) && (drain_cnt < NF);
    assign drain_addr = drain_cnt[AW-1:0];

    a_pair_distinct: assert property (
        @(posedge clk) disable iff (rst) ctrl.rd_en |-> (ctrl.rd_addr_a != ctrl.rd_addr_b)
    );

endmodule

// File: rtl/power_unit.sv
`timescale 1ns/1ps

module power_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_in,
    input  logic                                last_in,
    input  psd_pkg::cplx_t                      bin,
    output logic signed [psd_pkg::POWER_W-1:0]  power,
    output logic                                valid,
    output logic                                last
);
    import psd_pkg::*;

    localparam int SQ_W = 2 * SAMPLE_W + 1;

    localparam logic signed [SQ_W-1:0] P_MAX =
        {{(SQ_W - POWER_W + 1){1'b0}}, {(POWER_W - 1){1'b1}}};

    logic signed [SQ_W-1:0] mag_sq;
    logic signed [SQ_W-1:0] scaled;

    assign mag_sq = bin.re * bin.re + bin.im * bin.im;
    assign scaled = mag_sq >>> Q_FRAC;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            last  <= 1'b0;
        end else begin
            valid <= valid_in;
            last  <= last_in;
        end
    end

    always_ff @(posedge clk) begin
        power <= (scaled > P_MAX) ? P_MAX[POWER_W-1:0] : scaled[POWER_W-1:0];   // Never negative
    end

endmodule

// File: rtl/periodogram_top.sv
`timescale 1ns/1ps

module periodogram_top #(
    parameter int NF = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                sample_valid,
    input  logic signed [psd_pkg::SAMPLE_W-1:0] sample_real,
    input  logic signed [psd_pkg::SAMPLE_W-1:0] sample_imag,
    output logic                                busy,
    output logic signed [psd_pkg::POWER_W-1:0]  periodogram_out,
    output logic                                periodogram_valid,
    output logic                                periodogram_last
);
    import psd_pkg::*;

    localparam int AW = $clog2(NF);

    cplx_t         sample_pair;
    cplx_t         drain_data;
    cplx_t         tw;
    logic          load_en;
    logic [AW-1:0] load_addr;
    logic [AW-1:0] tw_addr;
    logic          bfly_valid;
    logic          drain_en;
    logic [AW-1:0] drain_addr;
    logic          pwr_valid_in;
    logic          pwr_last_in;

    fft_mem_if #(.AW(AW)) mem_bus ();

    assign sample_pair.re = sample_real;
    assign sample_pair.im = sample_imag;

    fft_controller #(.NF(NF)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .busy         (busy),
        .tw_addr      (tw_addr),
        .bfly_valid   (bfly_valid),
        .drain_en     (drain_en),
        .drain_addr   (drain_addr),
        .pwr_valid_in (pwr_valid_in),
        .pwr_last_in  (pwr_last_in),
        .ctrl         (mem_bus.ctrl)
    );

    frame_buffer #(.NF(NF)) u_buf (
        .clk        (clk),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (sample_pair),
        .drain_en   (drain_en),
        .drain_addr (drain_addr),
        .drain_data (drain_data),
        .mem        (mem_bus.mem)
    );

    twiddle_rom #(.NF(NF)) u_tw (
        .clk     (clk),
        .tw_addr (tw_addr),
        .tw      (tw)
    );

    butterfly_unit u_bfly (
        .clk        (clk),
        .rst        (rst),
        .bfly_valid (bfly_valid),
        .tw         (tw),
        .bfly       (mem_bus.bfly)
    );

    power_unit u_power (
        .clk      (clk),
        .rst      (rst),
        .valid_in (pwr_valid_in),
        .last_in  (pwr_last_in),
        .bin      (drain_data),
        .power    (periodogram_out),
        .valid    (periodogram_valid),
        .last     (periodogram_last)
    );

endmodule

// File: tests/tb_periodogram.sv
`timescale 1ns/1ps

module tb_periodogram;
    import psd_pkg::*;

    localparam int  NF           = 16;
    localparam int  LOG2_NF      = $clog2(NF);
    localparam int  NFRAMES      = 7;
    localparam int  TOL          = 4 * LOG2_NF + 8;   // Q30 LSBs lost to truncation
    localparam int  FRAME_CYCLES = NF + LOG2_NF * (NF / 2 + 3) + NF + 10;
    localparam int  MAX_CYCLES   = NFRAMES * FRAME_CYCLES * 2;
    localparam real PI           = 3.14159265358979;

    localparam int IMPULSE = 0;
    localparam int DC      = 1;
    localparam int CTONE   = 2;
    localparam int RTONE   = 3;
    localparam int RANDOM  = 4;

    logic                       clk;
    logic                       rst;
    logic                       sample_valid;
    logic signed [SAMPLE_W-1:0] sample_real;
    logic signed [SAMPLE_W-1:0] sample_imag;
    logic                       busy;
    logic signed [POWER_W-1:0]  periodogram_out;
    logic                       periodogram_valid;
    logic                       periodogram_last;

    string  f_name  [NFRAMES];
    int     f_kind  [NFRAMES];
    int     f_amp   [NFRAMES];
    int     f_bin   [NFRAMES];
    int     f_peak  [NFRAMES];   // Power in the loaded bins, -1 if only the model applies
    bit     f_junk  [NFRAMES];   // Hold sample_valid high while busy
    bit     f_reset [NFRAMES];   // Reset partway through a first load

    int     x_re  [NF];
    int     x_im  [NF];
    int     ref_p [NF];
    int     got_p [NF];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    periodogram_top #(.NF(NF)) uut (
        .clk               (clk),
        .rst               (rst),
        .sample_valid      (sample_valid),
        .sample_real       (sample_real),
        .sample_imag       (sample_imag),
        .busy              (busy),
        .periodogram_out   (periodogram_out),
        .periodogram_valid (periodogram_valid),
        .periodogram_last  (periodogram_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped by timeout after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic set_frame(input int i, input string name, input int kind, input int amp,
                             input int k, input int peak, input bit junk, input bit rst_mid);
        f_name[i]  = name;
        f_kind[i]  = kind;
        f_amp[i]   = amp;
        f_bin[i]   = k;
        f_peak[i]  = peak;
        f_junk[i]  = junk;
        f_reset[i] = rst_mid;
    endtask

    task automatic load_table();
        set_frame(0, "impulse", IMPULSE, 32000, 0, 122, 1'b0, 1'b0);   // (A/NF)^2 >> 15
        set_frame(1, "dc", DC, 8000, 0, 1953, 1'b0, 1'b0);
        set_frame(2, "complex_tone_k3", CTONE, 20000, 3, 12207, 1'b0, 1'b0);
        set_frame(3, "real_tone_k5", RTONE, 24000, 5, 4394, 1'b0, 1'b0);   // (A/2)^2 >> 15
        set_frame(4, "random", RANDOM, 16384, 0, -1, 1'b1, 1'b0);
        set_frame(5, "impulse_after_busy", IMPULSE, 32000, 0, 122, 1'b0, 1'b0);
        set_frame(6, "real_tone_after_reset", RTONE, 16000, 2, 1953, 1'b0, 1'b1);
    endtask

    function automatic int round_int(input real v);
        if (v >= 0.0) begin
            return $rtoi(v + 0.5);
        end
        return -$rtoi(0.5 - v);
    endfunction

    function automatic bit carries_power(input int i, input int b);
        case (f_kind[i])
            IMPULSE: return 1'b1;
            DC:      return b == 0;
            CTONE:   return b == f_bin[i];
            RTONE:   return (b == f_bin[i]) || (b == NF - f_bin[i]);
            default: return 1'b0;
        endcase
    endfunction

    task automatic make_samples(input int i);
        real ang;
        for (int n = 0; n < NF; n++) begin
            ang     = 2.0 * PI * n * f_bin[i] / NF;
            x_re[n] = 0;
            x_im[n] = 0;
            case (f_kind[i])
                IMPULSE: x_re[n] = (n == 0) ? f_amp[i] : 0;
                DC:      x_re[n] = f_amp[i];
                CTONE: begin
                    x_re[n] = round_int(f_amp[i] * $cos(ang));
                    x_im[n] = round_int(f_amp[i] * $sin(ang));
                end
                RTONE:   x_re[n] = round_int(f_amp[i] * $cos(ang));
                default: begin
                    x_re[n] = $random(seed) % f_amp[i];
                    x_im[n] = $random(seed) % f_amp[i];
                end
            endcase
        end
    endtask

    // Scaled DFT in real arithmetic, then |X|^2 in Q30 shifted down by 15
    task automatic compute_reference();
        real xr;
        real xi;
        real ang;
        for (int k = 0; k < NF; k++) begin
            xr = 0.0;
            xi = 0.0;
            for (int n = 0; n < NF; n++) begin
                ang = 2.0 * PI * n * k / NF;
                xr  = xr + x_re[n] * $cos(ang) + x_im[n] * $sin(ang);
                xi  = xi + x_im[n] * $cos(ang) - x_re[n] * $sin(ang);
            end
            xr       = xr / NF;
            xi       = xi / NF;
            ref_p[k] = $rtoi((xr * xr + xi * xi) / (2.0 ** Q_FRAC));
        end
    endtask

    task automatic drive_samples(input int count);
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_real  <= SAMPLE_W'(x_re[n]);
            sample_imag  <= SAMPLE_W'(x_im[n]);
        end
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    task automatic reset_mid_load();
        drive_samples(NF / 2);
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (periodogram_valid || busy) begin
                $display("Output or busy seen after a reset during load");
                errors++;
            end
        end
    endtask

    task automatic collect_bins(input int i);
        int count;
        bit last_seen;
        bit junk_on;
        count     = 0;
        last_seen = 1'b0;
        for (int b = 0; b < NF; b++) begin
            got_p[b] = -1;
        end
        while (!last_seen && count < NF) begin
            @(negedge clk);
            if (!busy) begin
                $display("Frame %s: busy low before bin %0d arrived", f_name[i], count);
                errors++;
            end
            if (periodogram_valid) begin
                if (periodogram_last != (count == NF - 1)) begin
                    $display("Frame %s: periodogram_last wrong on bin %0d", f_name[i], count);
                    errors++;
                end
                got_p[count] = periodogram_out;
                count++;
                last_seen = periodogram_last;
            end else if (periodogram_last) begin
                $display("Frame %s: periodogram_last without a valid bin", f_name[i]);
                errors++;
            end
            junk_on = f_junk[i] && busy && !last_seen;   // Must all be ignored
            @(posedge clk);
            sample_valid <= junk_on;
            if (junk_on) begin
                sample_real <= SAMPLE_W'($random(seed));
                sample_imag <= SAMPLE_W'($random(seed));
            end
        end
        if (!last_seen) begin
            $display("Frame %s: no periodogram_last after %0d bins", f_name[i], count);
            errors++;
        end
        if (count != NF) begin
            $display("Frame %s: got %0d valid bins instead of %0d", f_name[i], count, NF);
            errors++;
        end
        @(negedge clk);
        if (periodogram_valid) begin
            $display("Frame %s: extra valid bin after the last one", f_name[i]);
            errors++;
        end
        if (busy) begin
            $display("Frame %s: busy still high after the last bin", f_name[i]);
            errors++;
        end
    endtask

    task automatic check_frame(input int i);
        int  expect_cf;
        int  diff;
        int  sum_got;
        real mean_sq;
        sum_got = 0;
        mean_sq = 0.0;
        for (int b = 0; b < NF; b++) begin
            checks++;
            diff = got_p[b] - ref_p[b];
            if (diff > TOL || diff < -TOL) begin
                $display("FAILED %s bin %0d: expected %0d, actual %0d",
                         f_name[i], b, ref_p[b], got_p[b]);
                errors++;
            end
            if (f_peak[i] >= 0) begin
                expect_cf = carries_power(i, b) ? f_peak[i] : 0;
                checks++;
                diff = got_p[b] - expect_cf;
                if (diff > TOL || diff < -TOL) begin
                    $display("FAILED %s bin %0d closed form: expected %0d, actual %0d",
                             f_name[i], b, expect_cf, got_p[b]);
                    errors++;
                end
            end
            sum_got += got_p[b];
        end
        // Parseval, bins add up to mean |x|^2
        for (int n = 0; n < NF; n++) begin
            mean_sq = mean_sq + real'(x_re[n]) * x_re[n] + real'(x_im[n]) * x_im[n];
        end
        mean_sq = mean_sq / NF / (2.0 ** Q_FRAC);
        checks++;
        diff = sum_got - $rtoi(mean_sq);
        if (diff > TOL * NF || diff < -TOL * NF) begin
            $display("FAILED %s Parseval sum: expected %0d, actual %0d",
                     f_name[i], $rtoi(mean_sq), sum_got);
            errors++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample_real  = '0;
        sample_imag  = '0;
        seed         = 32'h6404;
        errors       = 0;
        checks       = 0;
        load_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NFRAMES; i++) begin
            make_samples(i);
            compute_reference();
            if (f_reset[i]) begin
                reset_mid_load();
            end
            drive_samples(NF);
            collect_bins(i);
            check_frame(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/twiddle_q15.mem
// Columns: cos(2*pi*k/64) and -sin(2*pi*k/64) in Q15, one line per k from 0 to 31
7FFF 0000
7F62 F374
7D8A E707
7A7D DAD8
7642 CF04
70E3 C3A9
6A6E B8E3
62F2 AECC
5A82 A57E
5134 9D0E
471D 9592
3C57 8F1D
30FC 89BE
2528 8583
18F9 8276
0C8C 809E
0000 8001
F374 809E
E707 8276
DAD8 8583
CF04 89BE
C3A9 8F1D
B8E3 9592
AECC 9D0E
A57E A57E
9D0E AECC
9592 B8E3
8F1D C3A9
89BE CF04
8583 DAD8
8276 E707
809E F374

// File: vlog.f
rtl/psd_pkg.sv
rtl/fft_mem_if.sv
rtl/frame_buffer.sv
rtl/twiddle_rom.sv
rtl/butterfly_unit.sv
rtl/fft_controller.sv
rtl/power_unit.sv
rtl/periodogram_top.sv
tests/tb_periodogram.sv

// File: Bender.yml
package:
  name: periodogram

sources:
  - files:
      - rtl/psd_pkg.sv
      - rtl/fft_mem_if.sv
      - rtl/frame_buffer.sv
      - rtl/twiddle_rom.sv
      - rtl/butterfly_unit.sv
      - rtl/fft_controller.sv
      - rtl/power_unit.sv
      - rtl/periodogram_top.sv
  - target: test
    files:
      - tests/tb_periodogram.sv
